// File: ber_settings.svh
`ifndef BER_SETTINGS_SVH
`define BER_SETTINGS_SVH

// PRBS7 pattern, taps 7 and 6
`define BER_PRBS_ORDER 7

// Pattern period, also sweep window length and number of offsets
`define BER_PRBS_PERIOD 127

// Clocks per bit strobe
`define BER_OS_RATIO 4

// Error, total and count length words
`define BER_CNT_W 32

// Latency and offset index
`define BER_LAT_W 7

`endif

// File: ber_pkg.sv
`default_nettype none

package ber_pkg;

  // Sequencer phases
  // IDLE   waiting for a start
  // SWEEP  every offset of the reference gets one pattern period
  // COUNT  error and total counting at the locked latency
  // DONE   results held until the next start
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    SWEEP = 2'd1,
    COUNT = 2'd2,
    DONE  = 2'd3
  } ber_state_e;

endpackage

`default_nettype wire

// File: ber_ctrl_if.sv
`default_nettype none
`timescale 1ns/1ns

interface ber_ctrl_if import ber_pkg::*; ();

  logic       strobe;      // One clock per bit
  logic       sweep_en;    // Offset sweep phase
  logic       count_en;    // BER counting phase
  logic       window_done; // Last strobe of the window
  logic       last_offset; // Window for the final offset
  ber_state_e state;       // Sequencer phase

  modport timer (
    output strobe,
    output window_done,
    output last_offset,
    input  sweep_en,
    input  count_en
  );

  modport seq (
    output sweep_en,
    output count_en,
    output state,
    input  window_done,
    input  last_offset
  );

  // Counter only watches
  modport counter (
    input strobe,
    input sweep_en,
    input count_en,
    input window_done,
    input last_offset,
    input state
  );

endinterface

`default_nettype wire

// File: prbs_gen.sv
`default_nettype none
`timescale 1ns/1ns

`include "ber_settings.svh"

module prbs_gen (
  input  logic clk,
  input  logic i_reset,
  input  logic i_en,
  input  logic i_strobe,
  output logic o_bit
);

  localparam int N = `BER_PRBS_ORDER;

  logic [N-1:0] lfsr;
  logic         feedback;

  // x^7 + x^6 + 1
  assign feedback = lfsr[N-1] ^ lfsr[N-2];

  always_ff @(posedge clk) begin
    if (i_reset || !i_en) begin
      lfsr <= '1; // All ones seed, never the lock-up state
    end else if (i_strobe) begin
      lfsr <= {lfsr[N-2:0], feedback};
    end
  end

  assign o_bit = lfsr[N-1];

endmodule

`default_nettype wire

// File: bit_timer.sv
`default_nettype none
`timescale 1ns/1ns

`include "ber_settings.svh"

module bit_timer (
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic [`BER_CNT_W-1:0] i_count_len,
  ber_ctrl_if.timer             ctrl
);

  localparam int DIV_W = $clog2(`BER_OS_RATIO);
  localparam int CW    = `BER_CNT_W;
  localparam int LW    = `BER_LAT_W;

  logic [DIV_W-1:0] div_cnt;
  logic             strobe_q;
  logic [CW-1:0]    win_cnt;  // Strobes left in window, minus one
  logic [LW-1:0]    off_cnt;  // Offset of the current sweep window
  logic             active;
  logic             win_end;
  logic             off_end;
  logic [CW-1:0]    reload;

  // Free-running prescaler, strobe on the clock after div_cnt wraps
  always_ff @(posedge clk) begin
    if (i_reset) begin
      div_cnt  <= '0;
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= (div_cnt == '0);
      if (div_cnt == DIV_W'(`BER_OS_RATIO - 1)) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  assign active  = ctrl.sweep_en | ctrl.count_en;
  assign win_end = strobe_q & active & (win_cnt == '0);
  assign off_end = ctrl.sweep_en & (off_cnt == LW'(`BER_PRBS_PERIOD - 1));

  // Last sweep window hands over to the count length
  assign reload = (ctrl.sweep_en && off_end) ? i_count_len - 1'b1 :
                  CW'(`BER_PRBS_PERIOD - 1);

  always_ff @(posedge clk) begin
    if (i_reset || !active) begin
      win_cnt <= CW'(`BER_PRBS_PERIOD - 1);
      off_cnt <= '0;
    end else if (strobe_q) begin
      if (win_end) begin
        win_cnt <= reload; // Next window starts here
        if (ctrl.sweep_en) begin
          off_cnt <= off_end ? '0 : off_cnt + 1'b1;
        end
      end else begin
        win_cnt <= win_cnt - 1'b1;
      end
    end
  end

  assign ctrl.strobe      = strobe_q;
  assign ctrl.window_done = win_end;
  assign ctrl.last_offset = off_end;

  a_strobe_single : assert property (@(posedge clk) disable iff (i_reset)
    strobe_q |=> !strobe_q);

endmodule

`default_nettype wire

// File: ber_sequencer.sv
`default_nettype none
`timescale 1ns/1ns

module ber_sequencer import ber_pkg::*; (
  input  logic     clk,
  input  logic     i_reset,
  input  logic     i_start,
  ber_ctrl_if.seq  ctrl,
  output logic     o_busy,
  output logic     o_lock,
  output logic     o_done
);

  ber_state_e state;
  ber_state_e state_nxt;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (i_start) begin
          state_nxt = SWEEP;
        end
      end
      SWEEP: begin
        // Whole sweep ends with the window of the last offset
        if (ctrl.window_done && ctrl.last_offset) begin
          state_nxt = COUNT;
        end
      end
      COUNT: begin
        if (ctrl.window_done) begin
          state_nxt = DONE;
        end
      end
      DONE: begin
        if (i_start) begin
          state_nxt = SWEEP; // Restart, counter clears itself
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  assign ctrl.state    = state;
  assign ctrl.sweep_en = (state == SWEEP);
  assign ctrl.count_en = (state == COUNT);

  assign o_busy = (state == SWEEP) || (state == COUNT);
  assign o_lock = (state == COUNT); // Latency found
  assign o_done = (state == DONE);

  a_phase_exclusive : assert property (@(posedge clk) disable iff (i_reset)
    !(ctrl.sweep_en && ctrl.count_en));

endmodule

`default_nettype wire

// File: ber_counter.sv
`default_nettype none
`timescale 1ns/1ns

`include "ber_settings.svh"

module ber_counter import ber_pkg::*; (
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_ref_bit,
  input  logic                  i_rx_bit,
  ber_ctrl_if.counter           ctrl,
  output logic [`BER_CNT_W-1:0] o_err,
  output logic [`BER_CNT_W-1:0] o_tot,
  output logic [`BER_LAT_W-1:0] o_lat,
  output logic                  o_ber_ok
);

  localparam int P  = `BER_PRBS_PERIOD;
  localparam int CW = `BER_CNT_W;
  localparam int LW = `BER_LAT_W;
  localparam int XW = CW + 6; // Room for errors x 50

  // Entry k is the reference bit from k+1 strobes ago
  logic [P-1:0]  ref_sr;

  logic [CW-1:0] err_q;
  logic [CW-1:0] tot_q;
  logic [CW-1:0] min_err;   // Fewest errors seen in a sweep window
  logic [LW-1:0] idx;       // Offset under test
  logic [LW-1:0] lat_q;
  ber_state_e    state_q;

  logic          sweep_start;
  logic [CW-1:0] err_base;
  logic [CW-1:0] tot_base;
  logic [CW-1:0] min_base;
  logic          sweep_miss;
  logic          count_miss;
  logic [CW-1:0] win_err;
  logic [XW-1:0] err_x50;

  always_ff @(posedge clk) begin
    if (ctrl.strobe) begin
      ref_sr <= {ref_sr[P-2:0], i_ref_bit};
    end
  end

  // New sweep, from IDLE or a restart in DONE
  assign sweep_start = (ctrl.state == SWEEP) && (state_q != SWEEP);

  always_comb begin
    err_base = sweep_start ? '0 : err_q;
    tot_base = sweep_start ? '0 : tot_q;
    min_base = sweep_start ? '1 : min_err;
  end

  assign sweep_miss = ref_sr[idx] ^ i_rx_bit;
  assign count_miss = ref_sr[lat_q] ^ i_rx_bit;
  assign win_err    = err_base + CW'(sweep_miss); // Includes the closing strobe

  always_ff @(posedge clk) begin
    if (i_reset) begin
      err_q   <= '0;
      tot_q   <= '0;
      min_err <= '1;
      idx     <= '0;
      lat_q   <= '0;
      state_q <= IDLE;
    end else begin
      state_q <= ctrl.state;
      err_q   <= err_base;
      tot_q   <= tot_base;
      min_err <= min_base;
      if (sweep_start) begin
        idx <= '0;
      end
      if (ctrl.strobe && ctrl.sweep_en) begin
        if (ctrl.window_done) begin
          if (win_err < min_base) begin
            min_err <= win_err;
            lat_q   <= idx;
          end
          idx   <= ctrl.last_offset ? '0 : idx + 1'b1;
          err_q <= '0; // Fresh window
        end else begin
          err_q <= win_err;
        end
      end else if (ctrl.strobe && ctrl.count_en) begin
        err_q <= err_base + CW'(count_miss);
        tot_q <= tot_base + 1'b1;
      end
    end
  end

  // Pass when errors x 50 < total
  assign err_x50  = XW'(err_q) * XW'(50);
  assign o_ber_ok = err_x50 < XW'(tot_q);

  assign o_err = err_q;
  assign o_tot = tot_q;
  assign o_lat = lat_q;

  a_idx_range : assert property (@(posedge clk) disable iff (i_reset)
    idx < LW'(P));

endmodule

`default_nettype wire

// File: ber_tester_top.sv
`default_nettype none
`timescale 1ns/1ns

`include "ber_settings.svh"

module ber_tester_top (
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_start,
  input  logic                  i_rx_bit,
  input  logic [`BER_CNT_W-1:0] i_count_len,
  output logic                  o_tx_bit,
  output logic                  o_busy,
  output logic                  o_lock,
  output logic                  o_done,
  output logic                  o_ber_ok,
  output logic [`BER_CNT_W-1:0] o_err_count,
  output logic [`BER_CNT_W-1:0] o_tot_count,
  output logic [`BER_LAT_W-1:0] o_lat
);

  logic prbs_en; // Pattern runs outside IDLE
  logic ref_bit;

  ber_ctrl_if u_ctrl ();

  assign prbs_en = o_busy | o_done;

  bit_timer u_timer (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_count_len (i_count_len),
    .ctrl        (u_ctrl.timer)
  );

  ber_sequencer u_seq (
    .clk     (clk),
    .i_reset (i_reset),
    .i_start (i_start),
    .ctrl    (u_ctrl.seq),
    .o_busy  (o_busy),
    .o_lock  (o_lock),
    .o_done  (o_done)
  );

  prbs_gen u_tx_prbs (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_en     (prbs_en),
    .i_strobe (u_ctrl.strobe),
    .o_bit    (o_tx_bit)
  );

  // Local copy in lockstep with transmit
  prbs_gen u_ref_prbs (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_en     (prbs_en),
    .i_strobe (u_ctrl.strobe),
    .o_bit    (ref_bit)
  );

  ber_counter u_counter (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_ref_bit (ref_bit),
    .i_rx_bit  (i_rx_bit),
    .ctrl      (u_ctrl.counter),
    .o_err     (o_err_count),
    .o_tot     (o_tot_count),
    .o_lat     (o_lat),
    .o_ber_ok  (o_ber_ok)
  );

endmodule

`default_nettype wire

// File: tb_ber_tester.sv
`default_nettype none
`timescale 1ns/1ns

`include "ber_settings.svh"

module tb_ber_tester;

  localparam int P       = `BER_PRBS_PERIOD;
  localparam int OS      = `BER_OS_RATIO;
  localparam int CW      = `BER_CNT_W;
  localparam int LW      = `BER_LAT_W;
  localparam int NROWS   = 6;
  localparam int TIMEOUT = 100000;

  logic          clk;
  logic          i_reset;
  logic          i_start;
  logic          i_rx_bit;
  logic [CW-1:0] i_count_len;
  logic          o_tx_bit;
  logic          o_busy;
  logic          o_lock;
  logic          o_done;
  logic          o_ber_ok;
  logic [CW-1:0] o_err_count;
  logic [CW-1:0] o_tot_count;
  logic [LW-1:0] o_lat;

  // Stimulus table: link delay, error spacing, count length
  int     row_d   [NROWS];
  int     row_n   [NROWS];
  int     row_len [NROWS];

  int     cur_d;
  int     cur_n;
  int     cur_len;
  bit     hist [P];    // Transmit bits, newest at index 0
  int     clk_cnt;     // Clocks since reset release
  logic   tx_s;
  logic   lock_s;
  logic   busy_s;
  logic   done_s;
  int     tx_run;      // Strobes since the pattern left its seed
  int     seen_bits;   // Count-phase bits so far
  int     inj_count;   // Bits flipped by the channel
  int     checks;
  int     errors;
  int     rows_run;
  bit     timed_out;
  integer seed;

  ber_tester_top i_dut (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_start     (i_start),
    .i_rx_bit    (i_rx_bit),
    .i_count_len (i_count_len),
    .o_tx_bit    (o_tx_bit),
    .o_busy      (o_busy),
    .o_lock      (o_lock),
    .o_done      (o_done),
    .o_ber_ok    (o_ber_ok),
    .o_err_count (o_err_count),
    .o_tot_count (o_tot_count),
    .o_lat       (o_lat)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    tx_s   <= o_tx_bit;
    lock_s <= o_lock;
    busy_s <= o_busy;
    done_s <= o_done;
  end

  // Loopback channel, one bit per strobe
  always @(posedge clk) begin : channel
    logic rx_next;
    logic exp_tx;
    if (i_reset) begin
      clk_cnt <= 0;
    end else begin
      clk_cnt <= clk_cnt + 1;
      if (clk_cnt % OS == 1) begin // DUT sees a strobe on this edge
        for (int k = P - 1; k > 0; k--) begin
          hist[k] = hist[k-1];
        end
        hist[0] = tx_s;
        // Seven seed ones then the x^7 + x^6 + 1 recurrence
        if (busy_s || done_s) begin
          tx_run = tx_run + 1;
          exp_tx = (tx_run <= 7) ? 1'b1 : (hist[6] ^ hist[7]);
          check_eq("o_tx_bit", longint'(tx_s), longint'(exp_tx));
        end else begin
          tx_run = 0;
        end
        if (busy_s && !lock_s) begin
          seen_bits = 0; // Sweep running, new row
          inj_count = 0;
        end
        rx_next = hist[cur_d-1]; // Lands on the next strobe
        if (lock_s) begin
          seen_bits = seen_bits + 1;
          if (cur_n != 0 && seen_bits < cur_len && (seen_bits + 1) % cur_n == 0) begin
            rx_next   = ~rx_next;
            inj_count = inj_count + 1;
          end
        end
        i_rx_bit <= rx_next;
      end
    end
  end

  task automatic set_row(input int r, input int d, input int n, input int len);
    row_d[r]   = d;
    row_n[r]   = n;
    row_len[r] = len;
  endtask

  task automatic check_eq(input string name, input longint got, input longint exp);
    checks = checks + 1;
    assert (got == exp) else begin
      errors = errors + 1;
      $display("Mismatch at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic hold_until_busy(input int r);
    int k;
    for (k = 0; k < TIMEOUT; k++) begin
      @(negedge clk);
      if (o_busy) break;
    end
    if (k == TIMEOUT) begin
      errors    = errors + 1;
      timed_out = 1'b1;
      $display("Row %0d: o_busy never rose within %0d clocks of i_start", r, TIMEOUT);
    end
  endtask

  task automatic watch_for_done(input int r);
    int k;
    for (k = 0; k < TIMEOUT; k++) begin
      @(negedge clk);
      if (o_done) break;
    end
    if (k == TIMEOUT) begin
      errors    = errors + 1;
      timed_out = 1'b1;
      $display("Row %0d: o_done never rose within %0d clocks", r, TIMEOUT);
    end
  endtask

  task automatic run_row(input int r);
    int errors_before;
    int exp_inj;
    bit exp_ok;
    errors_before = errors;
    @(posedge clk);
    cur_d       <= row_d[r];
    cur_n       <= row_n[r];
    cur_len     <= row_len[r];
    i_count_len <= CW'(row_len[r]);
    i_start     <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
    hold_until_busy(r);
    if (timed_out) return;
    @(negedge clk);
    check_eq("o_tot_count", longint'(o_tot_count), 0); // Cleared by the new start
    check_eq("o_done", longint'(o_done), 0);
    watch_for_done(r);
    if (timed_out) return;
    exp_inj = (row_n[r] == 0) ? 0 : row_len[r] / row_n[r];
    exp_ok  = (longint'(exp_inj) * 50) < longint'(row_len[r]);
    check_eq("injected errors", longint'(inj_count), longint'(exp_inj));
    check_eq("o_lat", longint'(o_lat), longint'(row_d[r] - 1));
    check_eq("o_err_count", longint'(o_err_count), longint'(inj_count));
    check_eq("o_tot_count", longint'(o_tot_count), longint'(row_len[r]));
    check_eq("o_ber_ok", longint'(o_ber_ok), longint'(exp_ok));
    rows_run = rows_run + 1;
    $display("Row %0d d=%0d n=%0d len=%0d: lat=%0d err=%0d tot=%0d ok=%0b %s",
             r, row_d[r], row_n[r], row_len[r], o_lat, o_err_count, o_tot_count,
             o_ber_ok, (errors == errors_before) ? "passed" : "FAILED");
  endtask

  initial begin
    i_reset     = 1'b1;
    i_start     = 1'b0;
    i_rx_bit    = 1'b0;
    i_count_len = '0;
    cur_d       = 1;
    cur_n       = 0;
    cur_len     = 0;
    tx_run      = 0;
    seen_bits   = 0;
    inj_count   = 0;
    checks      = 0;
    errors      = 0;
    rows_run    = 0;
    timed_out   = 1'b0;
    seed        = 32'hb717_d16f;

    set_row(0, 1, 0, 1000);   // Shortest delay
    set_row(1, P, 0, 500);    // Longest delay
    set_row(2, 40, 10, 1000); // Too many errors
    set_row(3, 64, 100, 2000);
    set_row(4, 1 + int'($unsigned($random(seed)) % P), 0, 800);
    set_row(5, 1 + int'($unsigned($random(seed)) % P), 50, 1500); // Right at the limit

    repeat (4) @(posedge clk);
    i_reset <= 1'b0;
    @(negedge clk);
    check_eq("o_busy", longint'(o_busy), 0);
    check_eq("o_lock", longint'(o_lock), 0);
    check_eq("o_done", longint'(o_done), 0);
    check_eq("o_err_count", longint'(o_err_count), 0);
    check_eq("o_tot_count", longint'(o_tot_count), 0);
    check_eq("o_lat", longint'(o_lat), 0);

    // Let the reference history fill before the first sweep
    repeat (4 * P * OS) @(posedge clk);

    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
      if (timed_out) break;
    end

    $display("Summary: %0d of %0d rows run, %0d checks, %0d errors",
             rows_run, NROWS, checks, errors);
    if (errors == 0 && rows_run == NROWS) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
ber_pkg.sv
ber_ctrl_if.sv
prbs_gen.sv
bit_timer.sv
ber_sequencer.sv
ber_counter.sv
ber_tester_top.sv
tb_ber_tester.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the BER tester testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ber_tester \
  -f src.f

./obj_dir/Vtb_ber_tester > sim.log 2>&1
cat sim.log

if grep -q '>>> FAIL' sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

grep -q '>>> PASS' sim.log
echo "Simulation passed"
